// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_div_exec \
  -f vlog.f --Mdir obj_dir -o sim_div
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# keep running past assertion errors so the summary gets printed
./obj_dir/sim_div +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation PASSED"
exit 0

// ==== testbench/div_exec_checker.sv ====
`timescale 1ns/1ps
`include "div_consts.svh"

module div_exec_checker (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic [1:0]            state_i,
  input logic                  accept_i,
  input logic                  stall_i,
  input logic                  can_go_i,
  input logic                  valid_i,
  input div_pkg::exec_result_t result_i
);

  // failure counts, summed for the testbench summary
  int stall_fails = 0;
  int drop_fails = 0;
  int hold_fails = 0;
  int latency_fails = 0;
  int fails;

  assign fails = stall_fails + drop_fails + hold_fails + latency_fails;

  // 2'b00 is the idle encoding of the stage fsm
  stall_only_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !stall_i |-> state_i == 2'b00) else begin
    stall_fails++;
    $error("stall_rs_o low outside the idle state");
  end

  // valid only drops on a handshake
  valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && !can_go_i |=> valid_i) else begin
    drop_fails++;
    $error("valid_o dropped without can_go_i");
  end

  result_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && !can_go_i |=> $stable(result_i)) else begin
    hold_fails++;
    $error("result_o changed under back-pressure");
  end

  // valid is high after edge DIV_LATENCY, so seen one sample later
  fixed_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    accept_i |-> ##(`DIV_LATENCY + 1) $rose(valid_i)) else begin
    latency_fails++;
    $error("valid_o did not rise at the fixed latency");
  end

endmodule

bind issue_exec_stage_div div_exec_checker u_checker (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .state_i  (state_r),
  .accept_i (accept),
  .stall_i  (stall_rs_o),
  .can_go_i (can_go_i),
  .valid_i  (valid_o),
  .result_i (result_o)
);

// ==== testbench/tb_div_exec.sv ====
`timescale 1ns/1ps
`include "div_consts.svh"

module tb_div_exec;
  import div_pkg::*;

  localparam int N_OPS     = 48;
  // entries below this index see back-pressure
  // the rest go back to back
  localparam int N_SLOW    = 32;
  localparam int MAX_STALL = 15;
  localparam int LIMIT     = N_OPS * (`DIV_LATENCY + MAX_STALL) + 200;

  logic         clk_i, reset_i, ready_rs_i, stall_rs_o, can_go_i, valid_o;
  rs_entry_t    rs_entry_i;
  exec_result_t result_o;
  rs_entry_t    entries [N_OPS];
  exec_result_t expq [$];
  logic [31:0]  lfsr = 32'hef7e;
  logic         backpressure;
  int           errors = 0;
  int           checked = 0;
  int           cycles = 0;

  div_exec_unit_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // fibonacci lfsr with taps 32 22 2 1
  // one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  // op bits are signed, remainder and word
  function automatic rs_entry_t make_entry(input logic [2:0] op, input logic [63:0] a, b);
    rs_entry_t e;
    e.a   = a;
    e.b   = b;
    e.cmd = {op, 7'(rand_bits(7))};
    e.tag = 4'(rand_bits(4));
    return e;
  endfunction

  // risc-v divide rules
  // word ops work on the extended low half
  function automatic exec_result_t model(input rs_entry_t e);
    exec_result_t       r;
    logic signed [63:0] sa, sb;
    logic [63:0]        v;
    logic               dz, ov;
    sa = e.a;
    sb = e.b;
    if (e.cmd.is_word) begin
      sa = e.cmd.is_signed ? 64'($signed(e.a[31:0])) : 64'(e.a[31:0]);
      sb = e.cmd.is_signed ? 64'($signed(e.b[31:0])) : 64'(e.b[31:0]);
    end
    dz = (sb == 0);
    ov = e.cmd.is_signed && sb == '1 &&
         sa == (e.cmd.is_word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000);
    if (dz)
      v = e.cmd.want_rem ? sa : '1;
    else if (ov)
      v = e.cmd.want_rem ? '0 : sa;
    else if (e.cmd.is_signed)
      v = e.cmd.want_rem ? sa % sb : sa / sb;
    else
      v = e.cmd.want_rem ? $unsigned(sa) % $unsigned(sb) : $unsigned(sa) / $unsigned(sb);
    r.value = e.cmd.is_word ? 64'($signed(v[31:0])) : v;
    r.cmd   = e.cmd;
    r.tag   = e.tag;
    r.flags = {ov, dz};
    return r;
  endfunction

  function automatic void build_stimulus();
    logic [2:0]  op;
    logic [63:0] a, b;
    // zero divisor in both widths
    // word ops get junk above bit 31
    entries[0] = make_entry(3'b100, rand_bits(64), 64'h0);
    entries[1] = make_entry(3'b010, rand_bits(64), 64'h0);
    entries[2] = make_entry(3'b101, rand_bits(64), 64'hdead_beef_0000_0000);
    entries[3] = make_entry(3'b111, rand_bits(64), 64'h0000_1234_0000_0000);
    // most negative over minus one
    entries[4] = make_entry(3'b100, 64'h8000_0000_0000_0000, '1);
    entries[5] = make_entry(3'b110, 64'h8000_0000_0000_0000, '1);
    entries[6] = make_entry(3'b101, 64'h5555_5555_8000_0000, 64'h0000_0001_ffff_ffff);
    entries[7] = make_entry(3'b111, 64'h0000_0000_8000_0000, 64'hffff_ffff);
    for (int i = 8; i < N_OPS; i++) begin
      op = 3'(rand_bits(3));
      a  = rand_bits(64);
      // shifted divisors spread the quotient sizes
      b  = rand_bits(64) >> rand_bits(6);
      entries[i] = make_entry(op, a, b);
    end
  endfunction

  // called 1 ns after an edge
  // returns 1 ns after the accepting edge
  task automatic send(input rs_entry_t e);
    rs_entry_i = e;
    ready_rs_i = 1'b1;
    // stall is registered so its value now holds through the next edge
    while (stall_rs_o) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    expq.push_back(model(e));
    ready_rs_i = 1'b0;
  endtask

  task automatic check_result();
    exec_result_t exp;
    assert (expq.size() == 1) else begin
      $display("Handshake with %0d entries in flight instead of one", expq.size());
      errors++;
    end
    if (expq.size() != 0) begin
      exp = expq.pop_front();
      assert (result_o === exp) else begin
        $display("FAIL result_o got %h expected %h", result_o, exp);
        errors++;
      end
    end
    checked++;
  endtask

  // execute stage side with random stalls while backpressure is set
  task automatic consume();
    int stretch;
    stretch = int'(rand_bits(4));
    forever begin
      @(posedge clk_i);
      #1;
      if (!valid_o) begin
        can_go_i = !backpressure;
      end else if (backpressure && stretch > 0) begin
        can_go_i = 1'b0;
        stretch--;
      end else begin
        can_go_i = 1'b1;
        check_result();
        stretch = int'(rand_bits(4));
      end
    end
  endtask

  initial begin
    reset_i      = 1'b1;
    ready_rs_i   = 1'b0;
    can_go_i     = 1'b0;
    rs_entry_i   = '0;
    backpressure = 1'b1;
    build_stimulus();
    repeat (5) @(posedge clk_i);
    #1;
    // stall must be high while reset is held
    assert (stall_rs_o) else begin
      $display("stall_rs_o low while reset is held");
      errors++;
    end
    reset_i = 1'b0;
    @(posedge clk_i);
    #1;
    assert (!stall_rs_o && !valid_o) else begin
      $display("stall_rs_o or valid_o still high one cycle after reset");
      errors++;
    end
    fork
      consume();
    join_none
    for (int i = 0; i < N_OPS; i++) begin
      if (i == N_SLOW) begin
        // drain the slow phase before execute goes always ready
        while (checked < N_SLOW) @(posedge clk_i);
        @(negedge clk_i);
        backpressure = 1'b0;
        @(posedge clk_i);
        #1;
      end
      send(entries[i]);
    end
    while (checked < N_OPS) @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    $display("Errors: %0d testbench checks, %0d checker assertions",
             errors, UUT.u_stage.u_checker.fails);
    if (errors == 0 && UUT.u_stage.u_checker.fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // run limit from op count and worst case cycles per op
  initial begin
    while (cycles < LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: %0d cycles passed with %0d of %0d results taken",
             cycles, checked, N_OPS);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== verilog/div_consts.svh ====
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// operand width, one machine word
`define DIV_XLEN 64

// reorder buffer tag width
`define DIV_TAG_W 4

// command word width
`define DIV_CMD_W 10

// one quotient bit per iteration
`define DIV_ITERS `DIV_XLEN

// accept edge to valid_o rising
// capture, iterations, done pulse, fsm step
`define DIV_LATENCY 66

`endif

// ==== verilog/div_exec_unit_top.sv ====
`timescale 1ns/1ps

module div_exec_unit_top (
  input  logic                  clk_i,
  input  logic                  reset_i,

  // reservation station side
  input  div_pkg::rs_entry_t    rs_entry_i,
  input  logic                  ready_rs_i,
  output logic                  stall_rs_o,

  // execute stage side
  input  logic                  can_go_i,
  output div_pkg::exec_result_t result_o,
  output logic                  valid_o
);

  // single entry divide stage
  issue_exec_stage_div u_stage (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs_entry_i (rs_entry_i),
    .ready_rs_i (ready_rs_i),
    .stall_rs_o (stall_rs_o),
    .can_go_i   (can_go_i),
    .result_o   (result_o),
    .valid_o    (valid_o)
  );

endmodule

// ==== verilog/div_operand_prep.sv ====
`timescale 1ns/1ps
`include "div_consts.svh"

module div_operand_prep (
  input  logic [`DIV_XLEN-1:0]  a_i,
  input  logic [`DIV_XLEN-1:0]  b_i,
  input  div_pkg::div_cmd_t     cmd_i,
  output div_pkg::div_operands_t ops_o
);

  localparam int XLEN = `DIV_XLEN;
  localparam int HALF = XLEN / 2;

  logic [XLEN-1:0] a_ext, b_ext;
  logic [XLEN-1:0] a_act, b_act;
  logic            a_neg, b_neg;
  logic            b_zero;
  logic            a_is_min, b_is_m1;

  // word mode: low half, sign or zero extended
  assign a_ext = cmd_i.is_signed ? {{HALF{a_i[HALF-1]}}, a_i[HALF-1:0]}
                                 : {{HALF{1'b0}}, a_i[HALF-1:0]};
  assign b_ext = cmd_i.is_signed ? {{HALF{b_i[HALF-1]}}, b_i[HALF-1:0]}
                                 : {{HALF{1'b0}}, b_i[HALF-1:0]};

  assign a_act = cmd_i.is_word ? a_ext : a_i;
  assign b_act = cmd_i.is_word ? b_ext : b_i;

  // sign bits only matter for signed ops
  assign a_neg = cmd_i.is_signed & a_act[XLEN-1];
  assign b_neg = cmd_i.is_signed & b_act[XLEN-1];

  assign b_zero = (b_act == '0);

  // most negative value at the active width
  assign a_is_min = cmd_i.is_word ? (a_i[HALF-1:0] == {1'b1, {(HALF-1){1'b0}}})
                                  : (a_i == {1'b1, {(XLEN-1){1'b0}}});
  // minus one is all ones in both widths once extended
  assign b_is_m1 = (b_act == '1);

  always_comb begin
    // unsigned magnitudes for the core
    ops_o.dividend_mag = a_neg ? (~a_act + 1'b1) : a_act;
    ops_o.divisor_mag  = b_neg ? (~b_act + 1'b1) : b_act;
    // quotient sign: operands differ, divisor nonzero
    ops_o.neg_quot     = (a_neg ^ b_neg) & ~b_zero;
    // remainder follows the dividend
    ops_o.neg_rem      = a_neg;
    ops_o.div_zero     = b_zero;
    ops_o.overflow     = cmd_i.is_signed & a_is_min & b_is_m1;
    // kept for the zero and overflow results
    ops_o.dividend     = a_act;
  end

endmodule

// ==== verilog/div_pkg.sv ====
`include "div_consts.svh"

package div_pkg;

  // command word as the reservation station sends it
  // dest is opaque here, passed on to execute
  typedef struct packed {
    logic                      is_signed;
    logic                      want_rem;
    logic                      is_word;
    logic [`DIV_CMD_W-4:0]     dest;
  } div_cmd_t;

  // one reservation station entry
  typedef struct packed {
    logic [`DIV_XLEN-1:0]      a;
    logic [`DIV_XLEN-1:0]      b;
    div_cmd_t                  cmd;
    logic [`DIV_TAG_W-1:0]     tag;
  } rs_entry_t;

  // prepared operands plus sign and special-case bookkeeping
  typedef struct packed {
    logic [`DIV_XLEN-1:0]      dividend_mag;
    logic [`DIV_XLEN-1:0]      divisor_mag;
    logic                      neg_quot;
    logic                      neg_rem;
    logic                      div_zero;
    logic                      overflow;
    logic [`DIV_XLEN-1:0]      dividend;
  } div_operands_t;

  // what goes downstream; flags[0] div by zero, flags[1] overflow
  typedef struct packed {
    logic [`DIV_XLEN-1:0]      value;
    div_cmd_t                  cmd;
    logic [`DIV_TAG_W-1:0]     tag;
    logic [1:0]                flags;
  } exec_result_t;

endpackage

// ==== verilog/div_restoring_core.sv ====
`timescale 1ns/1ps
`include "div_consts.svh"

module div_restoring_core (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  output logic [`DIV_XLEN-1:0] quotient_o,
  output logic [`DIV_XLEN-1:0] remainder_o,
  output logic                 done_o
);

  localparam int XLEN  = `DIV_XLEN;
  localparam int CNT_W = $clog2(`DIV_ITERS + 1);

  // datapath registers
  logic [XLEN-1:0]  rem_r;
  logic [XLEN-1:0]  quot_r;
  logic [XLEN-1:0]  divisor_r;

  // control
  logic [CNT_W-1:0] count_r;
  logic             run_r;
  logic             done_r;

  // one step of the restoring loop
  logic [XLEN:0]    shifted;
  logic [XLEN+1:0]  trial;
  logic             trial_neg;

  // partial remainder with next dividend bit shifted in
  assign shifted   = {rem_r, quot_r[XLEN-1]};
  assign trial     = {1'b0, shifted} - {2'b00, divisor_r};
  // borrow out means the divisor did not fit
  assign trial_neg = trial[XLEN+1];

  // quot_r starts as the dividend and fills with quotient bits
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_r     <= '0;
      quot_r    <= dividend_i;
      divisor_r <= divisor_i;
    end else if (run_r && count_r != CNT_W'(`DIV_ITERS)) begin
      // restore on negative, else keep the difference
      rem_r  <= trial_neg ? shifted[XLEN-1:0] : trial[XLEN-1:0];
      quot_r <= {quot_r[XLEN-2:0], ~trial_neg};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      run_r   <= 1'b0;
      done_r  <= 1'b0;
      count_r <= '0;
    end else begin
      // done is a single cycle pulse
      done_r <= 1'b0;
      if (start_i) begin
        run_r   <= 1'b1;
        count_r <= '0;
      end else if (run_r) begin
        if (count_r == CNT_W'(`DIV_ITERS)) begin
          // all bits retired
          run_r  <= 1'b0;
          done_r <= 1'b1;
        end else begin
          count_r <= count_r + 1'b1;
        end
      end
    end
  end

  assign quotient_o  = quot_r;
  assign remainder_o = rem_r;
  assign done_o      = done_r;

endmodule

// ==== verilog/div_result_select.sv ====
`timescale 1ns/1ps
`include "div_consts.svh"

module div_result_select (
  input  logic [`DIV_XLEN-1:0]   quotient_i,
  input  logic [`DIV_XLEN-1:0]   remainder_i,
  input  div_pkg::div_operands_t ops_i,
  input  div_pkg::div_cmd_t      cmd_i,
  output logic [`DIV_XLEN-1:0]   value_o
);

  localparam int XLEN = `DIV_XLEN;
  localparam int HALF = XLEN / 2;

  logic [XLEN-1:0] quot_s;
  logic [XLEN-1:0] rem_s;
  logic [XLEN-1:0] picked;
  logic [XLEN-1:0] full;

  // reapply signs to the unsigned core results
  assign quot_s = ops_i.neg_quot ? (~quotient_i + 1'b1) : quotient_i;
  assign rem_s  = ops_i.neg_rem ? (~remainder_i + 1'b1) : remainder_i;

  assign picked = cmd_i.want_rem ? rem_s : quot_s;

  always_comb begin
    if (ops_i.div_zero) begin
      // quotient all ones, remainder is the dividend
      full = cmd_i.want_rem ? ops_i.dividend : '1;
    end else if (ops_i.overflow) begin
      // min / -1: quotient is the dividend, nothing left over
      full = cmd_i.want_rem ? '0 : ops_i.dividend;
    end else begin
      full = picked;
    end
  end

  // word ops always sign extend bit 31, also the unsigned ones
  assign value_o = cmd_i.is_word ? {{HALF{full[HALF-1]}}, full[HALF-1:0]} : full;

endmodule

// ==== verilog/issue_exec_stage_div.sv ====
`timescale 1ns/1ps
`include "div_consts.svh"

module issue_exec_stage_div (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  div_pkg::rs_entry_t    rs_entry_i,
  input  logic                  ready_rs_i,
  output logic                  stall_rs_o,
  input  logic                  can_go_i,
  output div_pkg::exec_result_t result_o,
  output logic                  valid_o
);

  import div_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE = 2'b00,
    S_BUSY = 2'b01,
    S_DONE = 2'b10
  } state_e;

  state_e                state_r, state_n;
  logic                  stall_r;
  logic                  accept;

  // prep output and what is held for the selector
  div_operands_t         ops;
  div_operands_t         ops_r;
  div_cmd_t              cmd_r;
  logic [`DIV_TAG_W-1:0] tag_r;

  logic [`DIV_XLEN-1:0]  quotient;
  logic [`DIV_XLEN-1:0]  remainder;
  logic                  core_done;
  logic [`DIV_XLEN-1:0]  value;

  // take an entry only while idle and not stalling
  assign accept = ready_rs_i & ~stall_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      S_IDLE: if (accept) state_n = S_BUSY;
      S_BUSY: if (core_done) state_n = S_DONE;
      // held until execute takes it
      S_DONE: if (can_go_i) state_n = S_IDLE;
      default: state_n = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= S_IDLE;
      stall_r <= 1'b1;
    end else begin
      state_r <= state_n;
      // registered decode, stall is high unless idle
      stall_r <= (state_n != S_IDLE);
    end
  end

  // holding register, loaded on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ops_r <= ops;
      cmd_r <= rs_entry_i.cmd;
      tag_r <= rs_entry_i.tag;
    end
  end

  div_operand_prep u_prep (
    .a_i   (rs_entry_i.a),
    .b_i   (rs_entry_i.b),
    .cmd_i (rs_entry_i.cmd),
    .ops_o (ops)
  );

  // magnitudes go straight into the core on the accept edge
  div_restoring_core u_core (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (accept),
    .dividend_i  (ops.dividend_mag),
    .divisor_i   (ops.divisor_mag),
    .quotient_o  (quotient),
    .remainder_o (remainder),
    .done_o      (core_done)
  );

  div_result_select u_sel (
    .quotient_i  (quotient),
    .remainder_i (remainder),
    .ops_i       (ops_r),
    .cmd_i       (cmd_r),
    .value_o     (value)
  );

  assign result_o.value = value;
  assign result_o.cmd   = cmd_r;
  assign result_o.tag   = tag_r;
  assign result_o.flags = {ops_r.overflow, ops_r.div_zero};

  assign valid_o    = (state_r == S_DONE);
  assign stall_rs_o = stall_r;

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/div_pkg.sv
verilog/div_operand_prep.sv
verilog/div_restoring_core.sv
verilog/div_result_select.sv
verilog/issue_exec_stage_div.sv
verilog/div_exec_unit_top.sv
testbench/div_exec_checker.sv
testbench/tb_div_exec.sv
